// File: bus_checker.sv
`default_nettype none
`timescale 1ns/1ps
// Bus path monitor
// Checks read data and the fixed one-wait-state completion of every APB transfer

`include "vector_bus_params.svh"

module bus_checker (
	input  logic                  clk_sys,
	input  logic                  cold_reset,
	input  logic                  psel_i,
	input  logic                  penable_i,
	input  logic                  pwrite_i,
	input  logic [`VB_ADDR_W-1:0] paddr_i,
	input  logic [`VB_DATA_W-1:0] prdata_i,
	input  logic                  pready_i,
	input  logic [`VB_DATA_W-1:0] exp_rdata_i,
	output int                    data_errors_o,
	output int                    timing_errors_o
);

	int access_cycles;
	int data_errors;
	int timing_errors;

	assign data_errors_o   = data_errors;
	assign timing_errors_o = timing_errors;

	always @(posedge clk_sys) begin
		if (cold_reset) begin
			access_cycles = 0;
			data_errors   = 0;
			timing_errors = 0;
		end else begin
			if (psel_i && !penable_i) begin
				access_cycles = 0;
			end else if (psel_i && penable_i) begin
				access_cycles = access_cycles + 1;
				if (pready_i) begin
					// Completion belongs in the second access cycle
					if (access_cycles != 2) begin
						$display("At %0t pready_o came in access cycle %0d, not the second",
							$time, access_cycles);
						timing_errors = timing_errors + 1;
					end
					if (!pwrite_i && prdata_i !== exp_rdata_i) begin
						$display("Fail at %0t: prdata_o = %02h, expected %02h (paddr %04h)",
							$time, prdata_i, exp_rdata_i, paddr_i);
						data_errors = data_errors + 1;
					end
				end else if (access_cycles == 2) begin
					$display("At %0t pready_o is missing in the second access cycle", $time);
					timing_errors = timing_errors + 1;
				end
			end
			// Stray completion
			if (pready_i && !(psel_i && penable_i)) begin
				$display("At %0t pready_o is high outside an access phase", $time);
				timing_errors = timing_errors + 1;
			end
		end
	end

endmodule

`default_nettype wire

// File: cycle_decode.sv
`default_nettype none
`timescale 1ns/1ps
// Bus path stage 1
// Latches the APB request with its 8080 status word, classifies the cycle, decodes the port

`include "vector_bus_params.svh"

module cycle_decode
	import vector_bus_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  cold_reset,

	input  logic                  psel_i,
	input  logic                  penable_i,
	input  logic                  pwrite_i,
	input  logic [`VB_ADDR_W-1:0] paddr_i,
	input  logic [`VB_DATA_W-1:0] pwdata_i,
	input  logic [`VB_DATA_W-1:0] status_i,

	output logic                  s1_valid_o,
	output logic [`VB_ADDR_W-1:0] s1_addr_o,
	output logic [`VB_DATA_W-1:0] s1_wdata_o,
	output logic                  s1_write_o,
	output status_word_u          s1_status_o,
	output logic                  s1_is_io_o,
	output io_sel_e               s1_io_sel_o
);

	status_word_u req_status;
	logic         setup_phase;
	logic         io_cycle;
	logic         mem_cycle;
	logic         req_is_io;
	logic         req_write;
	io_sel_e      port_sel;

	assign req_status.raw = status_i;

	// One setup cycle per APB transfer
	assign setup_phase = psel_i & ~penable_i;

	// ----------------------------------------
	// Cycle kind
	// ----------------------------------------
	assign io_cycle  = req_status.f.io_read | req_status.f.io_write;
	assign mem_cycle = (req_status.f.ram_read | ~req_status.f.write_n) & ~io_cycle;

	// Interrupt acknowledge and halt go the I/O way and read FFh there
	assign req_is_io = ~mem_cycle | req_status.f.int_ack;

	// Nothing is written on interrupt acknowledge
	assign req_write = pwrite_i & ~req_status.f.int_ack
		& (mem_cycle | req_status.f.io_write);

	// ----------------------------------------
	// Port decode on the low address byte
	// ----------------------------------------
	always_comb begin
		port_sel = io_none;
		if (io_cycle & ~req_status.f.int_ack) begin
			case (paddr_i[7:0])
				`VB_PORT_JOYCTL,
				`VB_PORT_JOYCTL + 8'd1: port_sel = io_joy_ctl;
				`VB_PORT_JOYP:          port_sel = io_joy_p;
				`VB_PORT_JOYPU:         port_sel = io_joy_pu;
				`VB_PORT_JOYA:          port_sel = io_joy_a;
				`VB_PORT_JOYB:          port_sel = io_joy_b;
				`VB_PORT_EDISK:         port_sel = io_edisk;
				default:                port_sel = io_none;
			endcase
		end
	end

	// ----------------------------------------
	// Request latch
	// ----------------------------------------
	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			s1_valid_o <= 1'b0;
		end else begin
			s1_valid_o <= setup_phase;
		end
	end

	// Payload held until the next setup
	always_ff @(posedge clk_sys) begin
		if (setup_phase) begin
			s1_addr_o   <= paddr_i;
			s1_wdata_o  <= pwdata_i;
			s1_write_o  <= req_write;
			s1_status_o <= req_status;
			s1_is_io_o  <= req_is_io;
			s1_io_sel_o <= port_sel;
		end
	end

	// Access phase only ever follows a setup cycle
	a_penable_after_setup: assert property (@(posedge clk_sys) disable iff (cold_reset)
		$rose(penable_i) |-> psel_i && $past(psel_i));

endmodule

`default_nettype wire

// File: edisk_mapper.sv
`default_nettype none
`timescale 1ns/1ps
// Bus path stage 2
// Quasi-disk register and mapping of the CPU address onto a RAM page

`include "vector_bus_params.svh"

module edisk_mapper
	import vector_bus_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  cold_reset,

	input  logic                  s1_valid_i,
	input  logic [`VB_ADDR_W-1:0] s1_addr_i,
	input  logic [`VB_DATA_W-1:0] s1_wdata_i,
	input  logic                  s1_write_i,
	input  status_word_u          s1_status_i,
	input  logic                  s1_is_io_i,
	input  io_sel_e               s1_io_sel_i,

	output logic                  s2_valid_o,
	output logic [`VB_ADDR_W-1:0] s2_addr_o,
	output logic [`VB_DATA_W-1:0] s2_wdata_o,
	output logic                  s2_write_o,
	output logic                  s2_is_io_o,
	output io_sel_e               s2_io_sel_o,
	output logic [`VB_PAGE_W-1:0] s2_page_o
);

	logic [`VB_DATA_W-1:0] ed_reg;
	logic                  ed_win;
	logic                  ed_ram;
	logic                  ed_stack;
	logic                  mem_cycle;

	// ----------------------------------------
	// E-disk control register
	// ----------------------------------------
	// 7 E000-FFFF window, 6 8000-9FFF window, 5 window enable,
	// 4 stack enable, 3:2 stack page, 1:0 window page
	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			ed_reg <= '0;
		end else if (s1_valid_i & s1_write_i & s1_is_io_i & (s1_io_sel_i == io_edisk)) begin
			ed_reg <= s1_wdata_i;
		end
	end

	// ----------------------------------------
	// Page select
	// ----------------------------------------
	assign mem_cycle = ~s1_is_io_i;

	// A000-DFFF always, the other two quarters on request
	assign ed_win = s1_addr_i[15] & ((s1_addr_i[14] ^ s1_addr_i[13])
		| (ed_reg[7] & s1_addr_i[14] & s1_addr_i[13])
		| (ed_reg[6] & ~s1_addr_i[14] & ~s1_addr_i[13]));

	assign ed_ram   = ed_reg[5] & ed_win & mem_cycle;
	assign ed_stack = ed_reg[4] & s1_status_i.f.io_stack & mem_cycle;

	// Stack mapping wins over the window
	always_comb begin
		if (ed_stack) begin
			s2_page_o = {1'b0, ed_reg[3:2]} + 3'd1;
		end else if (ed_ram) begin
			s2_page_o = {1'b0, ed_reg[1:0]} + 3'd1;
		end else begin
			s2_page_o = '0;
		end
	end

	// Page is ready within the first access cycle so the RAM
	// can complete with a single wait state
	assign s2_valid_o  = s1_valid_i;
	assign s2_addr_o   = s1_addr_i;
	assign s2_wdata_o  = s1_wdata_i;
	assign s2_write_o  = s1_write_i;
	assign s2_is_io_o  = s1_is_io_i;
	assign s2_io_sel_o = s1_io_sel_i;

endmodule

`default_nettype wire

// File: mem_io_stage.sv
`default_nettype none
`timescale 1ns/1ps
// Bus path stage 3
// Main and e-disk RAM, joystick port and readbacks, read data and APB completion

`include "vector_bus_params.svh"

module mem_io_stage
	import vector_bus_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  cold_reset,

	input  logic                  s2_valid_i,
	input  logic [`VB_ADDR_W-1:0] s2_addr_i,
	input  logic [`VB_DATA_W-1:0] s2_wdata_i,
	input  logic                  s2_write_i,
	input  logic                  s2_is_io_i,
	input  io_sel_e               s2_io_sel_i,
	input  logic [`VB_PAGE_W-1:0] s2_page_i,

	input  logic [`VB_DATA_W-1:0] joy_a_i,
	input  logic [`VB_DATA_W-1:0] joy_b_i,

	output logic [`VB_DATA_W-1:0] prdata_o,
	output logic                  pready_o
);

	localparam int RAM_DEPTH = `VB_RAM_PAGES << `VB_ADDR_W;

	logic [`VB_DATA_W-1:0]           ram [0:RAM_DEPTH-1];
	logic [`VB_PAGE_W+`VB_ADDR_W-1:0] ram_idx;
	logic [`VB_DATA_W-1:0]           ram_q;
	logic                            mem_wr;
	logic                            io_wr;

	logic [`VB_DATA_W-1:0] joy_port;
	logic [`VB_DATA_W-1:0] joy_a_val;
	logic [`VB_DATA_W-1:0] joy_b_val;
	logic [`VB_DATA_W-1:0] joy_or;
	logic [`VB_DATA_W-1:0] joy_p_val;
	logic [`VB_DATA_W-1:0] joy_pu_val;
	logic [`VB_DATA_W-1:0] io_data;
	logic [`VB_DATA_W-1:0] io_q;
	logic                  rd_is_io;

	// Active-low readback of one joystick, fire buttons on top
	function automatic logic [`VB_DATA_W-1:0] joy_code(input logic [`VB_DATA_W-1:0] joy);
		joy_code = ~{joy[5], joy[4], 2'b00, joy[2], joy[3], joy[1], joy[0]};
	endfunction

	assign mem_wr = s2_valid_i & s2_write_i & ~s2_is_io_i;
	assign io_wr  = s2_valid_i & s2_write_i & s2_is_io_i;

	// ----------------------------------------
	// RAM
	// ----------------------------------------
	// Page 0 is the main 64K, pages 1-4 the e-disk
	assign ram_idx = {s2_page_i, s2_addr_i};

	always_ff @(posedge clk_sys) begin
		if (mem_wr) begin
			ram[ram_idx] <= s2_wdata_i;
		end
		if (s2_valid_i) begin
			ram_q <= ram[ram_idx];
		end
	end

	// ----------------------------------------
	// Joystick port
	// ----------------------------------------
	// 05h loads the byte, 04h sets or clears one bit
	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			joy_port <= '0;
		end else if (io_wr & (s2_io_sel_i == io_joy_ctl)) begin
			if (s2_addr_i[0]) begin
				joy_port <= s2_wdata_i;
			end else if (!s2_wdata_i[7]) begin
				joy_port[s2_wdata_i[3:1]] <= s2_wdata_i[0];
			end
		end
	end

	assign joy_a_val = joy_code(joy_a_i);
	assign joy_b_val = joy_code(joy_b_i);
	assign joy_or    = joy_a_i | joy_b_i;

	// Active high, both sticks merged
	assign joy_pu_val = {joy_or[3], joy_or[0], joy_or[2], joy_or[1], joy_or[4], joy_or[5], 2'b00};

	// Source picked by port bits 6:5
	always_comb begin
		case (joy_port[6:5])
			2'b00:   joy_p_val = joy_a_val & joy_b_val;
			2'b01:   joy_p_val = joy_a_val;
			2'b10:   joy_p_val = joy_b_val;
			default: joy_p_val = '1;
		endcase
	end

	// ----------------------------------------
	// Read data
	// ----------------------------------------
	always_comb begin
		case (s2_io_sel_i)
			io_joy_ctl: io_data = '0;
			io_joy_p:   io_data = joy_p_val;
			io_joy_pu:  io_data = joy_pu_val;
			io_joy_a:   io_data = joy_a_val;
			io_joy_b:   io_data = joy_b_val;
			default:    io_data = '1;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (s2_valid_i) begin
			io_q     <= io_data;
			rd_is_io <= s2_is_io_i;
		end
	end

	assign prdata_o = rd_is_io ? io_q : ram_q;

	// Completion in the second access cycle
	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			pready_o <= 1'b0;
		end else begin
			pready_o <= s2_valid_i;
		end
	end

	// One request per setup through the whole chain
	a_pready_single: assert property (@(posedge clk_sys) disable iff (cold_reset)
		pready_o |=> !pready_o);

endmodule

`default_nettype wire

// File: tb_vector_bus.sv
`default_nettype none
`timescale 1ns/1ps
// Testbench for the Vector 06C bus path
// Plays the transfer list from the golden file over APB and reports the result

`include "vector_bus_params.svh"

module tb_vector_bus;

	localparam int MAX_LINES = 64;

	logic                  clk_sys;
	logic                  cold_reset;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [`VB_ADDR_W-1:0] paddr;
	logic [`VB_DATA_W-1:0] pwdata;
	logic [`VB_DATA_W-1:0] status;
	logic [`VB_DATA_W-1:0] joy_a;
	logic [`VB_DATA_W-1:0] joy_b;
	logic [`VB_DATA_W-1:0] prdata;
	logic                  pready;
	logic [`VB_DATA_W-1:0] exp_rdata;

	// ----------------------------------------
	// Transfer list
	// ----------------------------------------
	logic [`VB_DATA_W-1:0] t_status [0:MAX_LINES-1];
	logic                  t_write  [0:MAX_LINES-1];
	logic [`VB_ADDR_W-1:0] t_addr   [0:MAX_LINES-1];
	logic [`VB_DATA_W-1:0] t_wdata  [0:MAX_LINES-1];
	logic [`VB_DATA_W-1:0] t_joy_a  [0:MAX_LINES-1];
	logic [`VB_DATA_W-1:0] t_joy_b  [0:MAX_LINES-1];
	logic [`VB_DATA_W-1:0] t_expect [0:MAX_LINES-1];

	int line_count  = 0;
	int line_idx;
	int load_errors = 0;
	int cycle_count = 0;
	int cycle_limit = 20;
	int data_errors;
	int timing_errors;

	vector_bus_top UUT (
		.clk_sys    (clk_sys),
		.cold_reset (cold_reset),
		.psel_i     (psel),
		.penable_i  (penable),
		.pwrite_i   (pwrite),
		.paddr_i    (paddr),
		.pwdata_i   (pwdata),
		.status_i   (status),
		.joy_a_i    (joy_a),
		.joy_b_i    (joy_b),
		.prdata_o   (prdata),
		.pready_o   (pready)
	);

	bus_checker u_checker (
		.clk_sys         (clk_sys),
		.cold_reset      (cold_reset),
		.psel_i          (psel),
		.penable_i       (penable),
		.pwrite_i        (pwrite),
		.paddr_i         (paddr),
		.prdata_i        (prdata),
		.pready_i        (pready),
		.exp_rdata_i     (exp_rdata),
		.data_errors_o   (data_errors),
		.timing_errors_o (timing_errors)
	);

	// 8 ns clock
	always #4 clk_sys = ~clk_sys;

	// Comment and blank lines scan as zero fields
	task automatic load_transfer_list();
		int                   fd;
		int                   n;
		logic [8*120-1:0]     line;
		logic [15:0]          f_st, f_wr, f_ad, f_wd, f_ja, f_jb, f_ex;
		fd = $fopen("vector_bus_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open vector_bus_golden.txt");
			load_errors++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				n = $sscanf(line, "%h %h %h %h %h %h %h",
					f_st, f_wr, f_ad, f_wd, f_ja, f_jb, f_ex);
				if (n == 7 && line_count < MAX_LINES) begin
					t_status[line_count] = f_st[7:0];
					t_write[line_count]  = f_wr[0];
					t_addr[line_count]   = f_ad;
					t_wdata[line_count]  = f_wd[7:0];
					t_joy_a[line_count]  = f_ja[7:0];
					t_joy_b[line_count]  = f_jb[7:0];
					t_expect[line_count] = f_ex[7:0];
					line_count++;
				end else if (n > 0) begin
					$display("Transfer line %0d is malformed or beyond the list size",
						line_count + 1);
					load_errors++;
				end
			end
			$fclose(fd);
		end
		if (line_count == 0) begin
			$display("The transfer list holds no transfers");
			load_errors++;
		end
	endtask

	// Setup cycle, then access phase until completion
	task automatic drive_transfer(input int idx);
		psel      <= 1'b1;
		penable   <= 1'b0;
		pwrite    <= t_write[idx];
		paddr     <= t_addr[idx];
		pwdata    <= t_wdata[idx];
		status    <= t_status[idx];
		joy_a     <= t_joy_a[idx];
		joy_b     <= t_joy_b[idx];
		exp_rdata <= t_expect[idx];
		@(posedge clk_sys);
		penable <= 1'b1;
		@(posedge clk_sys);
		while (!pready) begin
			@(posedge clk_sys);
		end
	endtask

	task automatic report_error_counts();
		$display("Errors: %0d data, %0d timing, %0d transfer list",
			data_errors, timing_errors, load_errors);
	endtask

	// ----------------------------------------
	// Cycle limit
	// ----------------------------------------
	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles before the transfer list finished", cycle_count);
			report_error_counts();
			$display("Some tests failed");
			$finish;
		end
	end

	initial begin
		clk_sys    = 1'b0;
		cold_reset = 1'b1;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		status     = '0;
		joy_a      = '0;
		joy_b      = '0;
		exp_rdata  = '0;
		load_transfer_list();
		cycle_limit = 4 * line_count + 20;
		repeat (4) @(posedge clk_sys);
		cold_reset <= 1'b0;
		@(posedge clk_sys);
		for (line_idx = 0; line_idx < line_count; line_idx++) begin
			drive_transfer(line_idx);
		end
		psel    <= 1'b0;
		penable <= 1'b0;
		repeat (2) @(posedge clk_sys);
		report_error_counts();
		if (data_errors + timing_errors + load_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vector_bus.f
+incdir+.
vector_bus_pkg.sv
cycle_decode.sv
edisk_mapper.sv
mem_io_stage.sv
vector_bus_top.sv
bus_checker.sv
tb_vector_bus.sv

// File: vector_bus_golden.txt
# status write addr wdata joy_a joy_b expect, all hex, expect unused on writes
# status bits 7..0 are ram_read io_read m1 io_write halt_ack stack write_n int_ack
# Main page writes and reads
00 1 1234 5A 00 00 00
00 1 FFFF 3C 00 00 00
82 0 1234 00 00 00 5A
A2 0 FFFF 00 00 00 3C
# E-disk window at A000 mapped to page 3, then back to the main page
00 1 A000 11 00 00 00
10 1 1010 22 00 00 00
00 1 A000 77 00 00 00
82 0 A000 00 00 00 77
10 1 1010 00 00 00 00
82 0 A000 00 00 00 11
# Stack cycles on the page from register bits 3:2
00 1 1000 12 00 00 00
10 1 1010 18 00 00 00
04 1 1000 EE 00 00 00
82 0 1000 00 00 00 12
86 0 1000 00 00 00 EE
10 1 1010 39 00 00 00
86 0 A000 00 00 00 77
10 1 1010 00 00 00 00
# Joystick readbacks and the joyP source select
42 0 0E0E 00 11 24 BE
42 0 0F0F 00 11 24 77
42 0 0606 00 11 24 36
42 0 0707 00 11 24 6C
10 1 0505 20 11 24 00
42 0 0606 00 11 24 BE
10 1 0404 0D 11 24 00
42 0 0606 00 11 24 FF
10 1 0404 0A 11 24 00
42 0 0606 00 11 24 77
42 0 0606 00 08 02 FD
42 0 0707 00 08 02 90
# Interrupt acknowledge and unused ports
23 0 0038 00 00 00 FF
23 1 1234 00 00 00 00
82 0 1234 00 00 00 5A
42 0 0808 00 00 00 FF

// File: vector_bus_params.svh
// Vector 06C bus path shared definitions
// Widths, RAM page count and the I/O port numbers decoded on the low address byte

`ifndef VECTOR_BUS_PARAMS_SVH
`define VECTOR_BUS_PARAMS_SVH

// ----------------------------------------
// Widths
// ----------------------------------------
`define VB_ADDR_W      16
`define VB_DATA_W      8
`define VB_PAGE_W      3

// Main page plus four e-disk pages
`define VB_RAM_PAGES   5

// ----------------------------------------
// I/O ports
// ----------------------------------------
`define VB_PORT_EDISK  8'h10
`define VB_PORT_JOYP   8'h06
`define VB_PORT_JOYPU  8'h07
`define VB_PORT_JOYA   8'h0E
`define VB_PORT_JOYB   8'h0F

// Base of the 04h/05h control pair
`define VB_PORT_JOYCTL 8'h04

`endif

// File: vector_bus_pkg.sv
`default_nettype none
// Vector 06C bus path types
// 8080 status word view and the I/O device select

`include "vector_bus_params.svh"

package vector_bus_pkg;

	// ----------------------------------------
	// 8080 status word
	// ----------------------------------------

	// Flag order as put out on the data bus during SYNC
	typedef struct packed {
		logic ram_read;
		logic io_read;
		logic m1;
		logic io_write;
		logic halt_ack;
		logic io_stack;
		logic write_n;
		logic int_ack;
	} status_flags_s;

	// Same byte seen raw or as flags
	typedef union packed {
		logic [`VB_DATA_W-1:0] raw;
		status_flags_s         f;
	} status_word_u;

	// ----------------------------------------
	// I/O select
	// ----------------------------------------

	// Ports of dropped devices decode to io_none
	typedef enum logic [2:0] {
		io_none    = 3'd0,
		io_joy_ctl = 3'd1,
		io_joy_p   = 3'd2,
		io_joy_pu  = 3'd3,
		io_joy_a   = 3'd4,
		io_joy_b   = 3'd5,
		io_edisk   = 3'd6
	} io_sel_e;

endpackage

`default_nettype wire

// File: vector_bus_top.sv
`default_nettype none
`timescale 1ns/1ps
// Vector 06C CPU memory and I/O path as an APB slave
// Chains cycle decode, e-disk mapping and the RAM/I/O stage

`include "vector_bus_params.svh"

module vector_bus_top
	import vector_bus_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  cold_reset,

	input  logic                  psel_i,
	input  logic                  penable_i,
	input  logic                  pwrite_i,
	input  logic [`VB_ADDR_W-1:0] paddr_i,
	input  logic [`VB_DATA_W-1:0] pwdata_i,
	input  logic [`VB_DATA_W-1:0] status_i,

	input  logic [`VB_DATA_W-1:0] joy_a_i,
	input  logic [`VB_DATA_W-1:0] joy_b_i,

	output logic [`VB_DATA_W-1:0] prdata_o,
	output logic                  pready_o
);

	// ----------------------------------------
	// Stage 1 to stage 2
	// ----------------------------------------
	logic                  s1_valid;
	logic [`VB_ADDR_W-1:0] s1_addr;
	logic [`VB_DATA_W-1:0] s1_wdata;
	logic                  s1_write;
	status_word_u          s1_status;
	logic                  s1_is_io;
	io_sel_e               s1_io_sel;

	// ----------------------------------------
	// Stage 2 to stage 3
	// ----------------------------------------
	logic                  s2_valid;
	logic [`VB_ADDR_W-1:0] s2_addr;
	logic [`VB_DATA_W-1:0] s2_wdata;
	logic                  s2_write;
	logic                  s2_is_io;
	io_sel_e               s2_io_sel;
	logic [`VB_PAGE_W-1:0] s2_page;

	cycle_decode u_decode (
		.clk_sys     (clk_sys),
		.cold_reset  (cold_reset),
		.psel_i      (psel_i),
		.penable_i   (penable_i),
		.pwrite_i    (pwrite_i),
		.paddr_i     (paddr_i),
		.pwdata_i    (pwdata_i),
		.status_i    (status_i),
		.s1_valid_o  (s1_valid),
		.s1_addr_o   (s1_addr),
		.s1_wdata_o  (s1_wdata),
		.s1_write_o  (s1_write),
		.s1_status_o (s1_status),
		.s1_is_io_o  (s1_is_io),
		.s1_io_sel_o (s1_io_sel)
	);

	edisk_mapper u_mapper (
		.clk_sys     (clk_sys),
		.cold_reset  (cold_reset),
		.s1_valid_i  (s1_valid),
		.s1_addr_i   (s1_addr),
		.s1_wdata_i  (s1_wdata),
		.s1_write_i  (s1_write),
		.s1_status_i (s1_status),
		.s1_is_io_i  (s1_is_io),
		.s1_io_sel_i (s1_io_sel),
		.s2_valid_o  (s2_valid),
		.s2_addr_o   (s2_addr),
		.s2_wdata_o  (s2_wdata),
		.s2_write_o  (s2_write),
		.s2_is_io_o  (s2_is_io),
		.s2_io_sel_o (s2_io_sel),
		.s2_page_o   (s2_page)
	);

	mem_io_stage u_mem_io (
		.clk_sys     (clk_sys),
		.cold_reset  (cold_reset),
		.s2_valid_i  (s2_valid),
		.s2_addr_i   (s2_addr),
		.s2_wdata_i  (s2_wdata),
		.s2_write_i  (s2_write),
		.s2_is_io_i  (s2_is_io),
		.s2_io_sel_i (s2_io_sel),
		.s2_page_i   (s2_page),
		.joy_a_i     (joy_a_i),
		.joy_b_i     (joy_b_i),
		.prdata_o    (prdata_o),
		.pready_o    (pready_o)
	);

endmodule

`default_nettype wire
